// File: list.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/aluExecute.sv
rtl/writebackSelect.sv
rtl/execCore.sv
verification/execCoreTb.sv

// File: rtl/aluExecute.sv
module aluExecute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    decValid,
    input  ctrlPkg::ctrlT           decCtrl,
    input  ctrlPkg::execReqT        decReq,
    output logic                    exValid,
    output ctrlPkg::ctrlT           exCtrl,
    output logic [isaPkg::XLEN-1:0] aluResult,
    output logic                    branchTaken,
    output logic [isaPkg::XLEN-1:0] target,
    output logic [isaPkg::XLEN-1:0] pcPlus4
);

    logic [isaPkg::XLEN-1:0] rsVal;
    logic [isaPkg::XLEN-1:0] rtVal;
    logic [isaPkg::XLEN-1:0] immExt;
    logic [isaPkg::XLEN-1:0] opB;
    logic [isaPkg::XLEN-1:0] aluRes;
    logic [isaPkg::XLEN-1:0] nextSeq;
    logic [isaPkg::XLEN-1:0] tgt;
    logic [4:0]              shiftAmt;
    logic                    condTrue;
    logic [15:0]             imm;

    assign rsVal   = decReq.rsVal;
    assign rtVal   = decReq.rtVal;
    assign imm     = decReq.instr.iType.imm;
    assign nextSeq = decReq.pc + 32'd4;

    assign immExt = (decCtrl.immKind == ctrlPkg::IMM_SIGN) ? {{16{imm[15]}}, imm}
                                                           : {16'b0, imm};
    assign opB      = (decCtrl.immKind == ctrlPkg::IMM_NONE) ? rtVal : immExt;
    assign shiftAmt = decCtrl.shiftByShamt ? decReq.instr.rType.shamt : rsVal[4:0];

    always_comb
    begin
        case (decCtrl.aluOp)
            ctrlPkg::ALU_ADD:  aluRes = rsVal + opB; // No overflow trap
            ctrlPkg::ALU_SUB:  aluRes = rsVal - opB;
            ctrlPkg::ALU_AND:  aluRes = rsVal & opB;
            ctrlPkg::ALU_OR:   aluRes = rsVal | opB;
            ctrlPkg::ALU_XOR:  aluRes = rsVal ^ opB;
            ctrlPkg::ALU_NOR:  aluRes = ~(rsVal | opB);
            ctrlPkg::ALU_SLT:  aluRes = {31'b0, $signed(rsVal) < $signed(opB)};
            ctrlPkg::ALU_SLTU: aluRes = {31'b0, rsVal < opB};
            ctrlPkg::ALU_SLL:  aluRes = rtVal << shiftAmt;
            ctrlPkg::ALU_SRL:  aluRes = rtVal >> shiftAmt;
            ctrlPkg::ALU_SRA:  aluRes = $unsigned($signed(rtVal) >>> shiftAmt);
            ctrlPkg::ALU_LUI:  aluRes = {imm, 16'b0};
            default:           aluRes = '0;
        endcase
    end

    always_comb
    begin
        case (decCtrl.brCond)
            ctrlPkg::BR_EQ:  condTrue = (rsVal == rtVal);
            ctrlPkg::BR_NE:  condTrue = (rsVal != rtVal);
            ctrlPkg::BR_LEZ: condTrue = rsVal[31] || (rsVal == '0);
            ctrlPkg::BR_GTZ: condTrue = !rsVal[31] && (rsVal != '0);
            ctrlPkg::BR_LTZ: condTrue = rsVal[31];
            ctrlPkg::BR_GEZ: condTrue = !rsVal[31];
            default:         condTrue = 1'b0;
        endcase
    end

    always_comb
    begin
        case (decCtrl.jumpKind)
            ctrlPkg::JMP_ABS: tgt = {nextSeq[31:28], decReq.instr.jType.target, 2'b00};
            ctrlPkg::JMP_REG: tgt = rsVal;
            default:          tgt = nextSeq + {{14{imm[15]}}, imm, 2'b00}; // Branch offset
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            exValid <= 1'b0;
        else
            exValid <= decValid;
    end

    always_ff @(posedge clk)
    begin
        if (decValid)
        begin
            exCtrl      <= decCtrl;
            aluResult   <= aluRes;
            branchTaken <= condTrue || (decCtrl.jumpKind != ctrlPkg::JMP_NONE);
            target      <= tgt;
            pcPlus4     <= nextSeq;
        end
    end

    // Only one item in flight, so back-to-back valids mean a lost handshake
    singleItem: assert property (@(posedge clk) disable iff (rst) exValid |=> !exValid);

endmodule

// File: rtl/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {
        IMM_SIGN,
        IMM_ZERO,
        IMM_NONE // Operand B is rtVal
    } immKindT;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LEZ,
        BR_GTZ,
        BR_LTZ,
        BR_GEZ
    } brCondT;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_ABS, // j/jal, pseudo-direct
        JMP_REG  // jr/jalr
    } jumpKindT;

    typedef struct packed {
        aluOpT                          aluOp;
        immKindT                        immKind;
        logic                           shiftByShamt;
        brCondT                         brCond;
        jumpKindT                       jumpKind;
        logic                           link;    // Write PC+4, not ALU result
        logic                           writeEn;
        logic [isaPkg::REG_IDX_W-1:0]   destReg;
        logic                           illegal;
    } ctrlT;

    typedef struct packed {
        isaPkg::instrT                  instr;
        logic [isaPkg::XLEN-1:0]        pc;
        logic [isaPkg::XLEN-1:0]        rsVal;
        logic [isaPkg::XLEN-1:0]        rtVal;
    } execReqT;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0]        writeData;
        logic [isaPkg::REG_IDX_W-1:0]   destReg;
        logic                           writeEn;
        logic [isaPkg::XLEN-1:0]        nextPc;
        logic                           illegal;
    } execRespT;

endpackage

// File: rtl/execCore.sv
module execCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  ctrlPkg::execReqT  wbDatIn,
    output logic              wbAck,
    output ctrlPkg::execRespT wbDatOut
);

    logic                    decValid;
    ctrlPkg::ctrlT           decCtrl;
    ctrlPkg::execReqT        decReq;
    logic                    exValid;
    ctrlPkg::ctrlT           exCtrl;
    logic [isaPkg::XLEN-1:0] aluResult;
    logic                    branchTaken;
    logic [isaPkg::XLEN-1:0] target;
    logic [isaPkg::XLEN-1:0] pcPlus4;

    instrDecoder uDecoder (
        .clk      (clk),
        .rst      (rst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck), // Frees the decoder for the next request
        .decValid (decValid),
        .decCtrl  (decCtrl),
        .decReq   (decReq)
    );

    aluExecute uExecute (
        .clk         (clk),
        .rst         (rst),
        .decValid    (decValid),
        .decCtrl     (decCtrl),
        .decReq      (decReq),
        .exValid     (exValid),
        .exCtrl      (exCtrl),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .target      (target),
        .pcPlus4     (pcPlus4)
    );

    writebackSelect uWriteback (
        .clk         (clk),
        .rst         (rst),
        .exValid     (exValid),
        .exCtrl      (exCtrl),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .target      (target),
        .pcPlus4     (pcPlus4),
        .wbAck       (wbAck),
        .wbDatOut    (wbDatOut)
    );

endmodule

// File: rtl/instrDecoder.sv
module instrDecoder (
    input  logic             clk,
    input  logic             rst,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  ctrlPkg::execReqT wbDatIn,
    input  logic             wbAck,
    output logic             decValid,
    output ctrlPkg::ctrlT    decCtrl,
    output ctrlPkg::execReqT decReq
);

    logic          busy;
    logic          accept;
    isaPkg::instrT ins;

    assign accept = wbCyc && wbStb && !busy;
    assign ins    = decReq.instr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy     <= 1'b0;
            decValid <= 1'b0;
        end
        else
        begin
            decValid <= accept;
            if (accept)
                busy <= 1'b1;
            else if (wbAck)
                busy <= 1'b0; // Response handed back
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            decReq <= wbDatIn;
    end

    always_comb
    begin
        decCtrl              = '0;
        decCtrl.aluOp        = ctrlPkg::ALU_ADD;
        decCtrl.immKind      = ctrlPkg::IMM_NONE;
        decCtrl.brCond       = ctrlPkg::BR_NONE;
        decCtrl.jumpKind     = ctrlPkg::JMP_NONE;
        decCtrl.destReg      = ins.iType.rt; // Rt for I-type
        decCtrl.writeEn      = 1'b1;
        decCtrl.shiftByShamt = !ins.rType.funct[2]; // sll/srl/sra vs sllv/srlv/srav
        case (ins.rType.opcode)
            isaPkg::OP_RTYPE:
            begin
                decCtrl.destReg = ins.rType.rd;
                case (ins.rType.funct)
                    isaPkg::FN_ADD, isaPkg::FN_ADDU: decCtrl.aluOp = ctrlPkg::ALU_ADD;
                    isaPkg::FN_SUB, isaPkg::FN_SUBU: decCtrl.aluOp = ctrlPkg::ALU_SUB;
                    isaPkg::FN_AND:                  decCtrl.aluOp = ctrlPkg::ALU_AND;
                    isaPkg::FN_OR:                   decCtrl.aluOp = ctrlPkg::ALU_OR;
                    isaPkg::FN_XOR:                  decCtrl.aluOp = ctrlPkg::ALU_XOR;
                    isaPkg::FN_NOR:                  decCtrl.aluOp = ctrlPkg::ALU_NOR;
                    isaPkg::FN_SLT:                  decCtrl.aluOp = ctrlPkg::ALU_SLT;
                    isaPkg::FN_SLTU:                 decCtrl.aluOp = ctrlPkg::ALU_SLTU;
                    isaPkg::FN_SLL, isaPkg::FN_SLLV: decCtrl.aluOp = ctrlPkg::ALU_SLL;
                    isaPkg::FN_SRL, isaPkg::FN_SRLV: decCtrl.aluOp = ctrlPkg::ALU_SRL;
                    isaPkg::FN_SRA, isaPkg::FN_SRAV: decCtrl.aluOp = ctrlPkg::ALU_SRA;
                    isaPkg::FN_JR:
                    begin
                        decCtrl.jumpKind = ctrlPkg::JMP_REG;
                        decCtrl.writeEn  = 1'b0; // Jump only
                    end
                    isaPkg::FN_JALR:
                    begin
                        decCtrl.jumpKind = ctrlPkg::JMP_REG;
                        decCtrl.link     = 1'b1; // rd = PC+4
                    end
                    default:
                    begin
                        decCtrl.illegal = 1'b1;
                        decCtrl.writeEn = 1'b0;
                    end
                endcase
            end
            isaPkg::OP_ADDI, isaPkg::OP_ADDIU: decCtrl.immKind = ctrlPkg::IMM_SIGN;
            isaPkg::OP_SLTI:
            begin
                decCtrl.immKind = ctrlPkg::IMM_SIGN;
                decCtrl.aluOp   = ctrlPkg::ALU_SLT;
            end
            isaPkg::OP_SLTIU:
            begin
                decCtrl.immKind = ctrlPkg::IMM_SIGN; // Sign-extended, compared unsigned
                decCtrl.aluOp   = ctrlPkg::ALU_SLTU;
            end
            isaPkg::OP_ANDI:
            begin
                decCtrl.immKind = ctrlPkg::IMM_ZERO;
                decCtrl.aluOp   = ctrlPkg::ALU_AND;
            end
            isaPkg::OP_ORI:
            begin
                decCtrl.immKind = ctrlPkg::IMM_ZERO;
                decCtrl.aluOp   = ctrlPkg::ALU_OR;
            end
            isaPkg::OP_XORI:
            begin
                decCtrl.immKind = ctrlPkg::IMM_ZERO;
                decCtrl.aluOp   = ctrlPkg::ALU_XOR;
            end
            isaPkg::OP_LUI:
            begin
                decCtrl.immKind = ctrlPkg::IMM_ZERO;
                decCtrl.aluOp   = ctrlPkg::ALU_LUI;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE, isaPkg::OP_BLEZ, isaPkg::OP_BGTZ:
            begin
                decCtrl.writeEn = 1'b0;
                case (ins.iType.opcode[1:0])
                    2'b00:   decCtrl.brCond = ctrlPkg::BR_EQ;
                    2'b01:   decCtrl.brCond = ctrlPkg::BR_NE;
                    2'b10:   decCtrl.brCond = ctrlPkg::BR_LEZ;
                    default: decCtrl.brCond = ctrlPkg::BR_GTZ;
                endcase
            end
            isaPkg::OP_REGIMM:
            begin
                decCtrl.writeEn = 1'b0;
                if (ins.iType.rt == isaPkg::REGIMM_BLTZ)
                    decCtrl.brCond = ctrlPkg::BR_LTZ;
                else if (ins.iType.rt == isaPkg::REGIMM_BGEZ)
                    decCtrl.brCond = ctrlPkg::BR_GEZ;
                else
                    decCtrl.illegal = 1'b1;
            end
            isaPkg::OP_J:
            begin
                decCtrl.jumpKind = ctrlPkg::JMP_ABS;
                decCtrl.writeEn  = 1'b0;
            end
            isaPkg::OP_JAL:
            begin
                decCtrl.jumpKind = ctrlPkg::JMP_ABS;
                decCtrl.link     = 1'b1;
                decCtrl.destReg  = isaPkg::LINK_REG;
            end
            default:
            begin
                decCtrl.illegal = 1'b1;
                decCtrl.writeEn = 1'b0;
            end
        endcase
    end

    // Busy must cover the item until its ack, or a held stb gets accepted again
    noAcceptWhileBusy: assert property (@(posedge clk) disable iff (rst) wbAck |-> busy);

endmodule

// File: rtl/isaPkg.sv
package isaPkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    localparam logic [REG_IDX_W-1:0] LINK_REG = 5'd31; // jal writes here

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01; // bltz/bgez, picked by rt
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_JAL    = 6'h03;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_BNE    = 6'h05;
    localparam logic [5:0] OP_BLEZ   = 6'h06;
    localparam logic [5:0] OP_BGTZ   = 6'h07;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_ADDIU  = 6'h09;
    localparam logic [5:0] OP_SLTI   = 6'h0a;
    localparam logic [5:0] OP_SLTIU  = 6'h0b;
    localparam logic [5:0] OP_ANDI   = 6'h0c;
    localparam logic [5:0] OP_ORI    = 6'h0d;
    localparam logic [5:0] OP_XORI   = 6'h0e;
    localparam logic [5:0] OP_LUI    = 6'h0f;

    // R-type funct codes, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [REG_IDX_W-1:0] REGIMM_BLTZ = 5'd0;
    localparam logic [REG_IDX_W-1:0] REGIMM_BGEZ = 5'd1;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [REG_IDX_W-1:0] rd;
        logic [4:0]           shamt;
        logic [5:0]           funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [15:0]          imm;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeT;

    // Same word, three field layouts
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrT;

endpackage

// File: rtl/writebackSelect.sv
module writebackSelect (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    exValid,
    input  ctrlPkg::ctrlT           exCtrl,
    input  logic [isaPkg::XLEN-1:0] aluResult,
    input  logic                    branchTaken,
    input  logic [isaPkg::XLEN-1:0] target,
    input  logic [isaPkg::XLEN-1:0] pcPlus4,
    output logic                    wbAck,
    output ctrlPkg::execRespT       wbDatOut
);

    always_ff @(posedge clk)
    begin
        if (rst)
            wbAck <= 1'b0;
        else
            wbAck <= exValid;
    end

    always_ff @(posedge clk)
    begin
        if (exValid)
        begin
            wbDatOut.writeData <= exCtrl.link ? pcPlus4 : aluResult;
            wbDatOut.destReg   <= exCtrl.destReg;
            wbDatOut.writeEn   <= exCtrl.writeEn && (exCtrl.destReg != '0); // $zero stays 0
            wbDatOut.nextPc    <= branchTaken ? target : pcPlus4;
            wbDatOut.illegal   <= exCtrl.illegal;
        end
    end

    // Classic cycle ends on one ack, a longer pulse would ack the next stb
    ackPulse: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbAck);

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module execCoreTb -f list.f -o execCoreSim \
    && ./obj_dir/execCoreSim 2>&1 | tee sim.log
grep -q "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verification/execCoreTb.sv
module execCoreTb;

    localparam int          TIMEOUT_CYCLES = 4000; // ~330 requests of 4 cycles plus margin
    localparam logic [31:0] SEED           = 32'hd704_54ca;

    localparam logic [5:0] ALU_FUNCTS [16] = '{
        isaPkg::FN_ADD, isaPkg::FN_ADDU, isaPkg::FN_SUB, isaPkg::FN_SUBU,
        isaPkg::FN_AND, isaPkg::FN_OR, isaPkg::FN_XOR, isaPkg::FN_NOR,
        isaPkg::FN_SLT, isaPkg::FN_SLTU, isaPkg::FN_SLL, isaPkg::FN_SRL,
        isaPkg::FN_SRA, isaPkg::FN_SLLV, isaPkg::FN_SRLV, isaPkg::FN_SRAV
    };

    localparam logic [31:0] EDGE_VALS [5] = '{
        32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff
    };

    logic              clk;
    logic              rst;
    logic              wbCyc;
    logic              wbStb;
    ctrlPkg::execReqT  wbDatIn;
    logic              wbAck;
    ctrlPkg::execRespT wbDatOut;

    ctrlPkg::execReqT  pending[$]; // Requests sent and not yet answered
    ctrlPkg::execReqT  gotReq;
    ctrlPkg::execRespT expResp;
    logic              ackLast    = 1'b0;
    int                cycleCount = 0;

    execCore dut (
        .clk      (clk),
        .rst      (rst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .wbDatOut (wbDatOut)
    );

    always #50 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else
            failRun($sformatf("Mismatch at time %0t: %s = 0x%08h, expected 0x%08h",
                              $time, name, got, exp));
    endtask

    function automatic logic keptAluFunct(input logic [5:0] fn);
        return fn inside {isaPkg::FN_ADD, isaPkg::FN_ADDU, isaPkg::FN_SUB, isaPkg::FN_SUBU,
                          isaPkg::FN_AND, isaPkg::FN_OR, isaPkg::FN_XOR, isaPkg::FN_NOR,
                          isaPkg::FN_SLT, isaPkg::FN_SLTU, isaPkg::FN_SLL, isaPkg::FN_SRL,
                          isaPkg::FN_SRA, isaPkg::FN_SLLV, isaPkg::FN_SRLV, isaPkg::FN_SRAV};
    endfunction

    // True for every kept instruction that produces a register result
    function automatic logic writesReg(input isaPkg::instrT ins);
        case (ins.rType.opcode)
            isaPkg::OP_RTYPE:
                return keptAluFunct(ins.rType.funct) || (ins.rType.funct == isaPkg::FN_JALR);
            isaPkg::OP_ADDI, isaPkg::OP_ADDIU, isaPkg::OP_SLTI, isaPkg::OP_SLTIU,
            isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_LUI,
            isaPkg::OP_JAL:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic ctrlPkg::execRespT refExec(input ctrlPkg::execReqT req);
        ctrlPkg::execRespT r;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       pc4;
        logic [31:0]       se;
        logic [31:0]       ze;
        logic [31:0]       brTarget;
        logic [15:0]       imm;
        logic [4:0]        sh;
        a        = req.rsVal;
        b        = req.rtVal;
        imm      = req.instr.iType.imm;
        sh       = req.instr.rType.shamt;
        pc4      = req.pc + 32'd4;
        se       = {{16{imm[15]}}, imm};
        ze       = {16'h0000, imm};
        brTarget = pc4 + {se[29:0], 2'b00}; // Word offset from the delay slot
        r         = '0;
        r.nextPc  = pc4;
        r.destReg = req.instr.iType.rt;
        case (req.instr.rType.opcode)
            isaPkg::OP_RTYPE:
            begin
                r.destReg = req.instr.rType.rd;
                case (req.instr.rType.funct)
                    isaPkg::FN_ADD, isaPkg::FN_ADDU: r.writeData = a + b;
                    isaPkg::FN_SUB, isaPkg::FN_SUBU: r.writeData = a - b;
                    isaPkg::FN_AND:  r.writeData = a & b;
                    isaPkg::FN_OR:   r.writeData = a | b;
                    isaPkg::FN_XOR:  r.writeData = a ^ b;
                    isaPkg::FN_NOR:  r.writeData = ~(a | b);
                    isaPkg::FN_SLT:  r.writeData = {31'b0, $signed(a) < $signed(b)};
                    isaPkg::FN_SLTU: r.writeData = {31'b0, a < b};
                    isaPkg::FN_SLL:  r.writeData = b << sh;
                    isaPkg::FN_SRL:  r.writeData = b >> sh;
                    isaPkg::FN_SRA:  r.writeData = $signed(b) >>> sh;
                    isaPkg::FN_SLLV: r.writeData = b << a[4:0];
                    isaPkg::FN_SRLV: r.writeData = b >> a[4:0];
                    isaPkg::FN_SRAV: r.writeData = $signed(b) >>> a[4:0];
                    isaPkg::FN_JR:   r.nextPc = a;
                    isaPkg::FN_JALR:
                    begin
                        r.nextPc    = a;
                        r.writeData = pc4; // Link into rd
                    end
                    default: r.illegal = 1'b1;
                endcase
            end
            isaPkg::OP_ADDI, isaPkg::OP_ADDIU: r.writeData = a + se;
            isaPkg::OP_SLTI:  r.writeData = {31'b0, $signed(a) < $signed(se)};
            isaPkg::OP_SLTIU: r.writeData = {31'b0, a < se};
            isaPkg::OP_ANDI:  r.writeData = a & ze;
            isaPkg::OP_ORI:   r.writeData = a | ze;
            isaPkg::OP_XORI:  r.writeData = a ^ ze;
            isaPkg::OP_LUI:   r.writeData = {imm, 16'h0000};
            isaPkg::OP_BEQ:   r.nextPc = (a == b) ? brTarget : pc4;
            isaPkg::OP_BNE:   r.nextPc = (a != b) ? brTarget : pc4;
            isaPkg::OP_BLEZ:  r.nextPc = ($signed(a) <= 0) ? brTarget : pc4;
            isaPkg::OP_BGTZ:  r.nextPc = ($signed(a) > 0) ? brTarget : pc4;
            isaPkg::OP_REGIMM:
            begin
                if (req.instr.iType.rt == isaPkg::REGIMM_BLTZ)
                    r.nextPc = ($signed(a) < 0) ? brTarget : pc4;
                else if (req.instr.iType.rt == isaPkg::REGIMM_BGEZ)
                    r.nextPc = ($signed(a) >= 0) ? brTarget : pc4;
                else
                    r.illegal = 1'b1;
            end
            isaPkg::OP_J: r.nextPc = {pc4[31:28], req.instr.jType.target, 2'b00};
            isaPkg::OP_JAL:
            begin
                r.nextPc    = {pc4[31:28], req.instr.jType.target, 2'b00};
                r.writeData = pc4;
                r.destReg   = isaPkg::LINK_REG;
            end
            default: r.illegal = 1'b1;
        endcase
        r.writeEn = writesReg(req.instr) && (r.destReg != 5'd0); // $zero never written
        return r;
    endfunction

    // One classic cycle: raise cyc/stb, wait for ack, then end the cycle
    task automatic sendRequest(input ctrlPkg::execReqT req);
        int waited;
        waited  = 0;
        wbDatIn = req;
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        pending.push_back(req);
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wbAck);
        assert (waited == 3)
        else
            failRun($sformatf("wbAck came %0d edges after the request instead of 3", waited));
        wbStb = 1'b0;
        wbCyc = 1'b0;
        @(negedge clk);
    endtask

    task automatic sendInstr(input logic [31:0] ins, input logic [31:0] rsV,
                             input logic [31:0] rtV);
        ctrlPkg::execReqT req;
        logic [31:0]      pcRaw;
        pcRaw     = $urandom();
        req.instr = ins;
        req.pc    = {pcRaw[31:2], 2'b00};
        req.rsVal = rsV;
        req.rtVal = rtV;
        sendRequest(req);
    endtask

    task automatic runAluTests(input int count);
        logic [31:0] rnd;
        logic [31:0] fields;
        for (int i = 0; i < count; i++)
        begin
            rnd    = $urandom();
            fields = $urandom();
            sendInstr({isaPkg::OP_RTYPE, fields[25:6], ALU_FUNCTS[rnd[3:0]]},
                      $urandom(), $urandom());
        end
    endtask

    task automatic runImmTests(input int count);
        logic [31:0] rnd;
        logic [31:0] fields;
        for (int i = 0; i < count; i++)
        begin
            rnd    = $urandom();
            fields = $urandom();
            sendInstr({3'b001, rnd[2:0], fields[25:0]}, $urandom(), $urandom()); // addi..lui
        end
    endtask

    task automatic runBranchTests(input int count);
        logic [31:0] v;
        logic [31:0] imm;
        for (int i = 0; i < count; i++)
        begin
            v   = (i < 5) ? EDGE_VALS[i] : $urandom();
            imm = $urandom();
            sendInstr({isaPkg::OP_BEQ, 5'd1, 5'd2, imm[15:0]}, v, v);
            sendInstr({isaPkg::OP_BEQ, 5'd1, 5'd2, imm[31:16]}, v, ~v);
            sendInstr({isaPkg::OP_BNE, 5'd3, 5'd4, imm[15:0]}, v, v);
            sendInstr({isaPkg::OP_BNE, 5'd3, 5'd4, imm[31:16]}, v, v + 32'd1);
            sendInstr({isaPkg::OP_BLEZ, 5'd5, 5'd0, imm[15:0]}, v, $urandom());
            sendInstr({isaPkg::OP_BGTZ, 5'd5, 5'd0, imm[31:16]}, v, $urandom());
            sendInstr({isaPkg::OP_REGIMM, 5'd6, isaPkg::REGIMM_BLTZ, imm[15:0]}, v, $urandom());
            sendInstr({isaPkg::OP_REGIMM, 5'd6, isaPkg::REGIMM_BGEZ, imm[31:16]}, v, $urandom());
        end
    endtask

    task automatic runJumpTests(input int count);
        logic [31:0] rnd;
        logic [31:0] fields;
        logic [4:0]  rd;
        for (int i = 0; i < count; i++)
        begin
            rnd    = $urandom();
            fields = $urandom();
            rd     = (i % 4 == 0) ? 5'd0 : rnd[15:11]; // Some links aimed at $zero
            sendInstr({isaPkg::OP_J, fields[25:0]}, $urandom(), $urandom());
            sendInstr({isaPkg::OP_JAL, fields[25:0]}, $urandom(), $urandom());
            sendInstr({isaPkg::OP_RTYPE, rnd[25:21], 15'd0, isaPkg::FN_JR},
                      $urandom(), $urandom());
            sendInstr({isaPkg::OP_RTYPE, rnd[25:21], 5'd0, rd, 5'd0, isaPkg::FN_JALR},
                      $urandom(), $urandom());
        end
    endtask

    task automatic runIllegalTests(input int count);
        logic [31:0] rnd;
        logic [31:0] fields;
        logic [5:0]  fn;
        logic [4:0]  rt;
        for (int i = 0; i < count; i++)
        begin
            rnd    = $urandom();
            fields = $urandom();
            fn     = rnd[11:6];
            while (keptAluFunct(fn) || fn == isaPkg::FN_JR || fn == isaPkg::FN_JALR)
                fn = fn + 6'd1;
            rt = (rnd[16:12] > 5'd1) ? rnd[16:12] : 5'd2; // Anything but bltz/bgez
            sendInstr({rnd[5:0] | 6'h10, fields[25:0]}, $urandom(), $urandom());
            sendInstr({isaPkg::OP_RTYPE, fields[25:6], fn}, $urandom(), $urandom());
            sendInstr({isaPkg::OP_REGIMM, fields[25:21], rt, fields[15:0]},
                      $urandom(), $urandom());
        end
    endtask

    // Response checker, sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            assert (!(wbAck && ackLast)) else failRun("wbAck stayed high for more than one cycle");
            if (wbAck)
            begin
                assert (pending.size() != 0) else failRun("wbAck arrived with no request open");
                gotReq  = pending.pop_front();
                expResp = refExec(gotReq);
                checkField("nextPc", wbDatOut.nextPc, expResp.nextPc);
                checkField("writeEn", 32'(wbDatOut.writeEn), 32'(expResp.writeEn));
                checkField("illegal", 32'(wbDatOut.illegal), 32'(expResp.illegal));
                if (writesReg(gotReq.instr))
                begin
                    checkField("writeData", wbDatOut.writeData, expResp.writeData);
                    checkField("destReg", 32'(wbDatOut.destReg), 32'(expResp.destReg));
                end
            end
            ackLast = wbAck;
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            failRun("Timeout: the tests did not finish within the cycle limit");
    end

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        wbCyc   = 1'b0;
        wbStb   = 1'b0;
        wbDatIn = '0;
        void'($urandom(SEED));
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (wbAck == 1'b0) else failRun("wbAck is high right after reset");
        runAluTests(70);
        runImmTests(50);
        runBranchTests(10);
        runJumpTests(12);
        runIllegalTests(25);
        $display("TB PASSED");
        $finish;
    end

endmodule
